// File: Makefile
# Verilator flow for the 64-bit ALU
# every variable can be overridden on the command line, for example make sim TOP=alu_tb

VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= alu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all lint build sim clean

all: sim

# static checks over the whole file list
lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP) $(VFLAGS)

# timing support runs the clock loop and the event waits of the testbench
build:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP) $(VFLAGS)

# the run passes only when the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
+incdir+testbench
verilog/alu_pkg.sv
verilog/alu_op_if.sv
verilog/alu_shifter.sv
verilog/alu_bitcount.sv
verilog/alu_multiplier.sv
verilog/alu_exec.sv
verilog/alu_top.sv
testbench/alu_tb.sv

// File: testbench/alu_ref.svh
/* ALU reference model */

`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// expected {cause, result} for one operation, worked out bit by bit from the ALU rules
function automatic logic [65:0] alu_expect(
	input alu_pkg::alu_opcode_t op_v,
	input logic [2:0] fn_v,
	input logic imm_v,
	input alu_pkg::alu_word_t a_v,
	input alu_pkg::alu_word_t b_v,
	input alu_pkg::alu_word_t c_v,
	input alu_pkg::alu_word_t i_v
);
	alu_pkg::alu_word_t x;        // second operand
	alu_pkg::alu_word_t y;        // second operand as the logic ops see it
	alu_pkg::alu_word_t r;
	alu_pkg::cause_t cz;
	logic [127:0] p;              // full product
	logic in_rng;                 // a sits inside the check range
	int n;
	x = imm_v ? i_v : b_v;
	r = '0;
	cz = alu_pkg::CAUSE_NONE;
	n = 0;
	case (op_v)
	alu_pkg::OP_ADD:
	begin
		r = a_v + x;
		if (fn_v == 3'd2 && r[63])
			r = ~r + 64'd1;           // negative sum is folded to its magnitude
		else if (fn_v != 3'd0 && fn_v != 3'd2)
			r = '0;
	end
	alu_pkg::OP_SUBF:   r = x - a_v;
	alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR:
	begin
		y = (fn_v == 3'd2) ? ~x : x;
		case (op_v)
		alu_pkg::OP_AND: r = a_v & y;
		alu_pkg::OP_OR:  r = a_v | y;
		default:         r = a_v ^ y;
		endcase
		if (fn_v == 3'd1)
			r = ~r;                   // inverted form
		else if (fn_v > 3'd2)
			r = '0;
	end
	alu_pkg::OP_SHIFT:
	begin
		// one bit position per step, so the rotates need no special case for zero
		r = a_v;
		n = int'(x[5:0]);
		for (int i = 0; i < n; i++)
			case (fn_v)
			3'd0:    r = {r[62:0], 1'b0};
			3'd1:    r = {1'b0, r[63:1]};
			3'd2:    r = {r[63], r[63:1]};
			3'd3:    r = {r[62:0], r[63]};
			default: r = {r[0], r[63:1]};
			endcase
		if (fn_v > 3'd4)
			r = '0;
	end
	alu_pkg::OP_BITCNT:
	begin
		case (fn_v)
		3'd0:    while (n < 64 && a_v[63-n]) n++;
		3'd1:    while (n < 64 && !a_v[63-n]) n++;
		3'd2:    n = $countones(a_v);
		3'd3:    while (n < 64 && !a_v[n]) n++;
		default: n = 0;
		endcase
		r = 64'(n);                   // a scan with no stopping bit ends at 64
	end
	alu_pkg::OP_MUL:
	begin
		if (fn_v == 3'd0)
		begin
			p = {64'd0, a_v} * {64'd0, x};
			r = p[63:0];
		end
		else if (fn_v == 3'd1 || fn_v == 3'd4)
		begin
			p = $signed({{64{a_v[63]}}, a_v}) * $signed({{64{x[63]}}, x});
			r = (fn_v == 3'd1) ? p[63:0] : p[127:64];
		end
	end
	alu_pkg::OP_CHK:
	begin
		case (fn_v[1:0])
		2'd0:    in_rng = (a_v >= b_v) && (a_v < c_v);    // [b, c)
		2'd1:    in_rng = (a_v >= b_v) && (a_v <= c_v);   // [b, c]
		2'd2:    in_rng = (a_v > b_v) && (a_v < c_v);     // (b, c)
		default: in_rng = (a_v > b_v) && (a_v <= c_v);    // (b, c]
		endcase
		if (fn_v[2] ? in_rng : !in_rng)
			cz = alu_pkg::CAUSE_CHK;
	end
	alu_pkg::OP_CMOV:
		if (fn_v == 3'd4)
			r = (a_v == '0) ? x : c_v;
		else if (fn_v == 3'd5)
			r = (a_v != '0) ? x : c_v;
	alu_pkg::OP_LOADA:
	begin
		// the index is added once per unit of scale, so 1, 2, 4 or 8 times
		r = a_v + i_v;
		for (int i = 0; i < (1 << fn_v[1:0]); i++)
			r = r + b_v;
	end
	default:
	begin
		r = 64'hDEAD_DEAD_DEAD_DEAD;
		cz = alu_pkg::CAUSE_UNIMP;
	end
	endcase
	return {cz, r};
endfunction

`endif

// File: testbench/alu_tb.sv
/* 64-bit ALU testbench */

`timescale 1ns/1ps

module alu_tb;

	localparam int max_cycles = 4000;                  // the tests need about 2900 cycles
	localparam logic [31:0] rand_seed = 32'h1f80_553e;

	logic clk;
	logic rst;
	logic ld;
	alu_pkg::alu_opcode_t op;
	logic [alu_pkg::fn_width-1:0] fn;
	logic use_imm;
	alu_pkg::alu_word_t a;
	alu_pkg::alu_word_t b;
	alu_pkg::alu_word_t c;
	alu_pkg::alu_word_t imm;
	alu_pkg::alu_word_t o;
	alu_pkg::cause_t exc;
	logic mul_done;

	logic check_en;               // inputs on the bus are a single cycle op to be checked
	logic mul_seen;               // a multiply has been started since reset
	logic [65:0] exp_q [$];       // expected {cause, result} waiting for the next falling edge
	int cycles = 0;

	alu_top dut (
		.clk(clk),
		.rst(rst),
		.ld(ld),
		.op(op),
		.fn(fn),
		.use_imm(use_imm),
		.a(a),
		.b(b),
		.c(c),
		.imm(imm),
		.o(o),
		.exc(exc),
		.mul_done(mul_done)
	);

	`include "alu_ref.svh"

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;    // 4 ns period
	end

	// ========================================
	// helpers
	// ========================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	function automatic alu_pkg::alu_word_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $urandom();
		lo = $urandom();
		return {hi, lo};
	endfunction

	// mostly the defined sub-functions, now and then any code at all
	function automatic logic [2:0] pick_fn(input alu_pkg::alu_opcode_t op_v, input logic [31:0] r);
		if (r[7:4] == 4'd0)
			return r[2:0];
		case (op_v)
		alu_pkg::OP_ADD:  return {1'b0, r[0], 1'b0};                    // 0 or 2
		alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR:
			return (r[1:0] == 2'd3) ? 3'd0 : {1'b0, r[1:0]};
		alu_pkg::OP_CMOV: return {2'b10, r[0]};                         // 4 or 5
		default:          return r[2:0];
		endcase
	endfunction

	// one operation per falling edge, checked by the compare process
	task automatic apply_op(input alu_pkg::alu_opcode_t op_v, input logic [2:0] fn_v,
		input logic imm_v, input alu_pkg::alu_word_t a_v, b_v, c_v, i_v);
		@(negedge clk);
		check_en = 1'b1;
		op = op_v;
		fn = fn_v;
		use_imm = imm_v;
		a = a_v;
		b = b_v;
		c = c_v;
		imm = i_v;
	endtask

	// ========================================
	// checks
	// ========================================
	// the expected value is taken from the inputs that the rising edge sees
	always @(posedge clk)
	begin
		if (check_en)
			exp_q.push_back(alu_expect(op, fn, use_imm, a, b, c, imm));
	end

	always @(negedge clk)
	begin : compare_results
		logic [65:0] e;
		// done must stay low from reset until the first multiply is started
		if (!mul_seen)
			assert (mul_done === 1'b0)
			else
				abort_run($sformatf("MISMATCH at %0t ns: mul_done expected 0, got %b",
					$time, mul_done));
		if (exp_q.size() != 0)
		begin
			e = exp_q.pop_front();
			assert (o === e[63:0])
			else
				abort_run($sformatf("MISMATCH at %0t ns: o expected %h, got %h",
					$time, e[63:0], o));
			assert (exc === e[65:64])
			else
				abort_run($sformatf("MISMATCH at %0t ns: exc expected %0d, got %0d",
					$time, e[65:64], exc));
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= max_cycles)
			abort_run($sformatf("timeout after %0d cycles, the tests did not finish", cycles));
	end

	// ========================================
	// stimulus
	// ========================================
	task automatic random_alu_ops(input int count);
		alu_pkg::alu_opcode_t pick;
		alu_pkg::alu_word_t av;
		logic [31:0] r;
		int k;
		for (int i = 0; i < count; i++)
		begin
			r = $urandom();
			k = $urandom_range(6, 0);
			case (k)
			0:       pick = alu_pkg::OP_ADD;
			1:       pick = alu_pkg::OP_SUBF;
			2:       pick = alu_pkg::OP_AND;
			3:       pick = alu_pkg::OP_OR;
			4:       pick = alu_pkg::OP_XOR;
			5:       pick = alu_pkg::OP_CMOV;
			default: pick = alu_pkg::OP_LOADA;
			endcase
			av = rand_word();
			if (pick == alu_pkg::OP_CMOV && r[8])
				av = '0;                              // both arms of the move get taken
			apply_op(pick, pick_fn(pick, r), r[9], av, rand_word(), rand_word(), rand_word());
		end
	endtask

	task automatic sweep_shifts();
		alu_pkg::alu_word_t x;
		logic [5:0] amt;
		logic [31:0] r;
		for (int f = 0; f < 8; f++)
			for (int j = 0; j < 9; j++)
			begin
				r = $urandom();
				case (j)
				0:       amt = 6'd0;
				1:       amt = 6'd1;
				2:       amt = 6'd31;
				3:       amt = 6'd32;
				4:       amt = 6'd63;
				default: amt = r[5:0];
				endcase
				x = rand_word();
				x[5:0] = amt;                             // upper amount bits are noise
				apply_op(alu_pkg::OP_SHIFT, 3'(f), r[6], rand_word(),
					r[6] ? rand_word() : x, rand_word(), r[6] ? x : rand_word());
			end
	endtask

	task automatic count_corner_words();
		alu_pkg::alu_word_t w;
		logic [31:0] r;
		for (int k = 0; k < 24; k++)
		begin
			r = $urandom();
			case (k)
			0:       w = '0;
			1:       w = '1;
			2:       w = 64'd1;
			3:       w = 64'h8000_0000_0000_0000;
			default: w = r[0] ? (rand_word() >> r[6:1]) : (rand_word() << r[6:1]);
			endcase
			if (k > 3 && r[7])
				w = ~w;                                   // long runs of ones at either end
			for (int f = 0; f < 4; f++)
				apply_op(alu_pkg::OP_BITCNT, 3'(f), r[8], w, rand_word(), rand_word(), rand_word());
		end
	endtask

	task automatic exercise_range_checks();
		alu_pkg::alu_word_t lo;
		alu_pkg::alu_word_t hi;
		alu_pkg::alu_word_t av;
		logic [31:0] r;
		for (int s = 0; s < 3; s++)
		begin
			r = $urandom();
			lo = (rand_word() >> 2) + 64'd1;            // room below the lower bound
			hi = lo + 64'd100 + {48'd0, r[15:0]};
			for (int p = 0; p < 5; p++)
			begin
				case (p)
				0:       av = lo - 64'd1;
				1:       av = lo;
				2:       av = lo + 64'd50;
				3:       av = hi;
				default: av = hi + 64'd1;
				endcase
				for (int f = 0; f < 8; f++)
					apply_op(alu_pkg::OP_CHK, 3'(f), r[20], av, lo, hi, rand_word());
			end
		end
	endtask

	task automatic try_undefined_ops();
		logic [31:0] r;
		for (int code = 11; code < 16; code++)
		begin
			r = $urandom();
			apply_op(alu_pkg::alu_opcode_t'(4'(code)), r[2:0], r[3], rand_word(),
				rand_word(), rand_word(), rand_word());
		end
	endtask

	// operands stay on the bus from ld until mul_done, the edge count is checked here
	task automatic multiply_and_check(input logic [2:0] f);
		alu_pkg::alu_word_t av;
		alu_pkg::alu_word_t bv;
		alu_pkg::alu_word_t iv;
		logic [65:0] e;
		logic [31:0] r;
		int n;
		r = $urandom();
		av = rand_word();
		bv = rand_word();
		iv = rand_word();
		e = alu_expect(alu_pkg::OP_MUL, f, r[0], av, bv, '0, iv);
		@(negedge clk);
		check_en = 1'b0;
		mul_seen = 1'b1;
		ld = 1'b1;
		op = alu_pkg::OP_MUL;
		fn = f;
		use_imm = r[0];
		a = av;
		b = bv;
		c = '0;
		imm = iv;
		@(negedge clk);
		ld = 1'b0;                                      // the ld edge has passed
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!mul_done && n < 16);
		assert (mul_done) else abort_run("mul_done never rose after ld");
		assert (n == 5)
		else
			abort_run($sformatf("mul_done rose %0d edges after ld instead of 5", n));
		assert (o === e[63:0])
		else
			abort_run($sformatf("MISMATCH at %0t ns: o (multiply fn %0d) expected %h, got %h",
				$time, f, e[63:0], o));
		assert (exc === alu_pkg::CAUSE_NONE)
		else
			abort_run($sformatf("MISMATCH at %0t ns: exc expected 0, got %0d", $time, exc));
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial
	begin
		void'($urandom(rand_seed));
		rst = 1'b1;
		ld = 1'b0;
		op = alu_pkg::alu_opcode_t'(4'd15);  // unknown opcode, so o and exc differ from reset
		fn = '0;
		use_imm = 1'b0;
		a = '0;
		b = '0;
		c = '0;
		imm = '0;
		check_en = 1'b0;
		mul_seen = 1'b0;
		repeat (10) @(negedge clk);
		// the outputs still show their reset values while rst is high
		assert (mul_done === 1'b0)
		else
			abort_run($sformatf("MISMATCH at %0t ns: mul_done expected 0, got %b", $time, mul_done));
		assert (o === '0)
		else
			abort_run($sformatf("MISMATCH at %0t ns: o expected 0, got %h", $time, o));
		assert (exc === alu_pkg::CAUSE_NONE)
		else
			abort_run($sformatf("MISMATCH at %0t ns: exc expected 0, got %0d", $time, exc));
		rst = 1'b0;
		random_alu_ops(500);
		sweep_shifts();
		count_corner_words();
		exercise_range_checks();
		try_undefined_ops();
		for (int i = 0; i < 100; i++)
		begin
			multiply_and_check(3'd0);
			multiply_and_check(3'd1);
			multiply_and_check(3'd4);
		end
		@(negedge clk);
		assert (exp_q.size() == 0) else abort_run("some expected results were never compared");
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: verilog/alu_bitcount.sv
/* bit count unit */

`timescale 1ns/1ps

module alu_bitcount (
	alu_op_if.unit opi,
	output alu_pkg::alu_word_t lead_ones,
	output alu_pkg::alu_word_t lead_zeros,
	output alu_pkg::alu_word_t pop_count,
	output alu_pkg::alu_word_t trail_zeros
);

	alu_pkg::alu_word_t a_rev;                      // a with bit order reversed
	logic [alu_pkg::shamt_width:0] lo_cnt;          // counts reach 64 so they need 7 bits
	logic [alu_pkg::shamt_width:0] lz_cnt;
	logic [alu_pkg::shamt_width:0] tz_cnt;
	logic [alu_pkg::shamt_width:0] pop_cnt;

	// length of the run of ones starting at the top bit
	// a word with no zero in it runs the whole width and yields 64
	function automatic logic [alu_pkg::shamt_width:0] lead_run(input alu_pkg::alu_word_t w);
		logic [alu_pkg::shamt_width:0] n;
		logic run;
		n = '0;
		run = 1'b1;
		for (int i = alu_pkg::data_width - 1; i >= 0; i--)
		begin
			run = run & w[i];                         // drops for good at the first zero
			n = n + {{alu_pkg::shamt_width{1'b0}}, run};
		end
		return n;
	endfunction

	assign a_rev = {<<{opi.a}};

	// ========================================
	// counts
	// ========================================
	// the zero counts reuse the ones scan on the inverted word
	assign lo_cnt = lead_run(opi.a);
	assign lz_cnt = lead_run(~opi.a);
	assign tz_cnt = lead_run(~a_rev);                 // trailing end becomes the leading end

	always_comb
	begin
		pop_cnt = '0;
		for (int i = 0; i < alu_pkg::data_width; i++)
			pop_cnt = pop_cnt + {{alu_pkg::shamt_width{1'b0}}, opi.a[i]};
	end

	// zero extend to a full result word
	assign lead_ones   = {{(alu_pkg::data_width-alu_pkg::shamt_width-1){1'b0}}, lo_cnt};
	assign lead_zeros  = {{(alu_pkg::data_width-alu_pkg::shamt_width-1){1'b0}}, lz_cnt};
	assign pop_count   = {{(alu_pkg::data_width-alu_pkg::shamt_width-1){1'b0}}, pop_cnt};
	assign trail_zeros = {{(alu_pkg::data_width-alu_pkg::shamt_width-1){1'b0}}, tz_cnt};

endmodule

// File: verilog/alu_exec.sv
/* ALU execute and result register */

`timescale 1ns/1ps

module alu_exec (
	input logic clk,
	input logic rst,
	alu_op_if.unit opi,
	input alu_pkg::alu_word_t shift_res,
	input alu_pkg::alu_word_t lead_ones,
	input alu_pkg::alu_word_t lead_zeros,
	input alu_pkg::alu_word_t pop_count,
	input alu_pkg::alu_word_t trail_zeros,
	input alu_pkg::alu_word_t mul_lo_u,
	input alu_pkg::alu_word_t mul_lo_s,
	input alu_pkg::alu_word_t mul_hi_s,
	output alu_pkg::alu_word_t o,
	output alu_pkg::cause_t exc
);

	alu_pkg::alu_word_t x;          // imm or b as the second operand
	alu_pkg::alu_word_t sum;        // a + x
	alu_pkg::alu_word_t sum_abs;    // magnitude of the sum, taken as two's complement
	alu_pkg::alu_word_t addr;       // scaled address
	alu_pkg::alu_word_t bus;        // selected result ahead of the register
	alu_pkg::cause_t cause;         // exception ahead of the register
	logic lo_ok;                    // a clears the lower bound
	logic hi_ok;                    // a clears the upper bound
	logic chk_fault;

	assign x = opi.use_imm ? opi.imm : opi.b;
	assign sum = opi.a + x;
	assign sum_abs = sum[alu_pkg::data_width-1] ? -sum : sum;
	assign addr = opi.a + opi.imm + (opi.b << opi.fn[1:0]);     // index scaled by 1, 2, 4 or 8

	// ========================================
	// range check
	// ========================================
	// fn[1] makes the lower bound exclusive, fn[0] makes the upper bound inclusive
	// and fn[2] flips the sense so that landing inside the range is the fault
	always_comb
	begin
		lo_ok = opi.fn[1] ? (opi.a > opi.b) : (opi.a >= opi.b);
		hi_ok = opi.fn[0] ? (opi.a <= opi.c) : (opi.a < opi.c);
		chk_fault = opi.fn[2] ? (lo_ok && hi_ok) : !(lo_ok && hi_ok);
	end

	// ========================================
	// result select
	// ========================================
	always_comb
	begin
		bus = '0;
		cause = alu_pkg::CAUSE_NONE;
		case (opi.op)
		alu_pkg::OP_ADD:
			case (opi.fn)
			3'd0:    bus = sum;
			3'd2:    bus = sum_abs;
			default: bus = '0;
			endcase
		alu_pkg::OP_SUBF:   bus = x - opi.a;   // reverse subtract
		alu_pkg::OP_AND:
			case (opi.fn)
			3'd0:    bus = opi.a & x;
			3'd1:    bus = ~(opi.a & x);      // nand
			3'd2:    bus = opi.a & ~x;        // and with complement
			default: bus = '0;
			endcase
		alu_pkg::OP_OR:
			case (opi.fn)
			3'd0:    bus = opi.a | x;
			3'd1:    bus = ~(opi.a | x);      // nor
			3'd2:    bus = opi.a | ~x;
			default: bus = '0;
			endcase
		alu_pkg::OP_XOR:
			case (opi.fn)
			3'd0:    bus = opi.a ^ x;
			3'd1:    bus = ~(opi.a ^ x);      // xnor
			3'd2:    bus = opi.a ^ ~x;
			default: bus = '0;
			endcase
		alu_pkg::OP_SHIFT:  bus = shift_res;
		alu_pkg::OP_BITCNT:
			case (opi.fn)
			3'd0:    bus = lead_ones;
			3'd1:    bus = lead_zeros;
			3'd2:    bus = pop_count;
			3'd3:    bus = trail_zeros;
			default: bus = '0;
			endcase
		alu_pkg::OP_MUL:
			// products come from the last pipeline stage
			case (opi.fn)
			3'd0:    bus = mul_lo_u;
			3'd1:    bus = mul_lo_s;
			3'd4:    bus = mul_hi_s;
			default: bus = '0;
			endcase
		alu_pkg::OP_CHK:
			if (chk_fault)
				cause = alu_pkg::CAUSE_CHK;    // result stays zero either way
		alu_pkg::OP_CMOV:
			case (opi.fn)
			3'd4:    bus = ~|opi.a ? x : opi.c;  // move when a is zero
			3'd5:    bus = |opi.a ? x : opi.c;   // move when a is nonzero
			default: bus = '0;
			endcase
		alu_pkg::OP_LOADA:  bus = addr;
		default:
		begin
			bus = alu_pkg::filler_word;
			cause = alu_pkg::CAUSE_UNIMP;
		end
		endcase
	end

	// one cycle from operands to o and exc
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			o <= '0;
			exc <= alu_pkg::CAUSE_NONE;
		end
		else
		begin
			o <= bus;
			exc <= cause;
		end
	end

endmodule

// File: verilog/alu_multiplier.sv
/* pipelined 64x64 multiplier */

`timescale 1ns/1ps

module alu_multiplier (
	input logic clk,
	input logic rst,
	alu_op_if.unit opi,
	input logic ld,
	output alu_pkg::alu_word_t mul_lo_u,
	output alu_pkg::alu_word_t mul_lo_s,
	output alu_pkg::alu_word_t mul_hi_s,
	output logic mul_done
);

	alu_pkg::alu_word_t x;                                        // chosen second operand
	logic [2*alu_pkg::data_width-1:0] prod_s [alu_pkg::mul_latency]; // signed stages
	logic [2*alu_pkg::data_width-1:0] prod_u [alu_pkg::mul_latency]; // unsigned stages
	logic [3:0] mul_cnt;                                          // done shift counter
	logic mul_armed;                                              // set once a multiply started

	assign x = opi.use_imm ? opi.imm : opi.b;

	// ========================================
	// product pipeline
	// ========================================
	// samples every edge, the caller holds the operands steady while a multiply runs
	always_ff @(posedge clk)
	begin
		prod_s[0] <= $signed(opi.a) * $signed(x);
		prod_u[0] <= opi.a * x;
		for (int k = 1; k < alu_pkg::mul_latency; k++)
		begin
			prod_s[k] <= prod_s[k-1];
			prod_u[k] <= prod_u[k-1];
		end
	end

	assign mul_lo_u = prod_u[alu_pkg::mul_latency-1][alu_pkg::data_width-1:0];
	assign mul_lo_s = prod_s[alu_pkg::mul_latency-1][alu_pkg::data_width-1:0];
	assign mul_hi_s = prod_s[alu_pkg::mul_latency-1][2*alu_pkg::data_width-1:alu_pkg::data_width];

	// ========================================
	// done counter
	// ========================================
	// ld empties the counter and ones walk in from the bottom, the top bit is seen four
	// edges later and lands on mul_done one edge after that
	// until the first ld the fill bit is zero so done stays low out of reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mul_cnt <= 4'd0;
			mul_armed <= 1'b0;
			mul_done <= 1'b0;
		end
		else
		begin
			if (ld)
			begin
				mul_cnt <= 4'd0;     // restart even with products still in flight
				mul_armed <= 1'b1;
			end
			else
				mul_cnt <= {mul_cnt[2:0], mul_armed};
			mul_done <= mul_cnt[3];  // level, held until the next ld clears it
		end
	end

endmodule

// File: verilog/alu_op_if.sv
/* decoded ALU operation bundle */

`timescale 1ns/1ps

interface alu_op_if;

	alu_pkg::alu_opcode_t op;              // major opcode
	logic [alu_pkg::fn_width-1:0] fn;      // sub-function
	logic use_imm;                         // second operand comes from imm instead of b
	alu_pkg::alu_word_t a;                 // first operand
	alu_pkg::alu_word_t b;                 // second operand, or the lower bound of a check
	alu_pkg::alu_word_t c;                 // upper bound of a check, or the cmov fallback
	alu_pkg::alu_word_t imm;               // immediate value

	// the functional units only ever read the operation
	modport unit (
		input op,
		input fn,
		input use_imm,
		input a,
		input b,
		input c,
		input imm
	);

endinterface

// File: verilog/alu_pkg.sv
/* 64-bit ALU shared definitions */

package alu_pkg;

	// ========================================
	// widths
	// ========================================
	localparam int data_width = 64;    // operand and result width
	localparam int shamt_width = 6;    // shift amount, and a count is one bit wider
	localparam int fn_width = 3;       // sub-function field
	localparam int mul_latency = 3;    // product register stages

	typedef logic [data_width-1:0] alu_word_t;

	// ========================================
	// encodings
	// ========================================
	// codes 11 to 15 are left undefined and decode as unimplemented
	typedef enum logic [3:0] {
		OP_ADD    = 4'd0,  // add and absolute of sum
		OP_SUBF   = 4'd1,  // reverse subtract
		OP_AND    = 4'd2,
		OP_OR     = 4'd3,
		OP_XOR    = 4'd4,
		OP_SHIFT  = 4'd5,  // shifts and rotates
		OP_BITCNT = 4'd6,  // leading, trailing and population counts
		OP_MUL    = 4'd7,  // pipelined multiply
		OP_CHK    = 4'd8,  // range check that may raise an exception
		OP_CMOV   = 4'd9,  // conditional move on a
		OP_LOADA  = 4'd10  // scaled address add
	} alu_opcode_t;

	typedef enum logic [1:0] {
		CAUSE_NONE  = 2'd0,
		CAUSE_CHK   = 2'd1,  // range check failed
		CAUSE_UNIMP = 2'd2   // opcode not implemented
	} cause_t;

	// result pattern for an unknown opcode
	localparam alu_word_t filler_word = {(data_width/16){16'hDEAD}};

endpackage

// File: verilog/alu_shifter.sv
/* shift and rotate unit */

`timescale 1ns/1ps

module alu_shifter (
	alu_op_if.unit opi,
	output alu_pkg::alu_word_t shift_res
);

	logic [alu_pkg::shamt_width-1:0] amt;           // shift distance
	logic [2*alu_pkg::data_width-1:0] shl;          // a in the low half moved up
	logic [2*alu_pkg::data_width-1:0] shr;          // a in the high half moved down
	logic [2*alu_pkg::data_width-1:0] asr;          // same as shr but sign filled

	// only the low bits of the amount matter, larger values wrap around
	always_comb
	begin
		if (opi.use_imm)
			amt = opi.imm[alu_pkg::shamt_width-1:0];
		else
			amt = opi.b[alu_pkg::shamt_width-1:0];
	end

	// ========================================
	// double width shifts
	// ========================================
	// the bits pushed out of one half land in the other half, which gives the rotates
	// for free by or-ing both halves together
	assign shl = {{alu_pkg::data_width{1'b0}}, opi.a} << amt;
	assign shr = {opi.a, {alu_pkg::data_width{1'b0}}} >> amt;
	assign asr = $signed({opi.a, {alu_pkg::data_width{1'b0}}}) >>> amt;

	// result select
	always_comb
	begin
		case (opi.fn)
		3'd0:    shift_res = shl[alu_pkg::data_width-1:0];                   // shl
		3'd1:    shift_res = shr[2*alu_pkg::data_width-1:alu_pkg::data_width]; // shr
		3'd2:    shift_res = asr[2*alu_pkg::data_width-1:alu_pkg::data_width]; // asr
		3'd3:                                                                  // rol
			shift_res = shl[2*alu_pkg::data_width-1:alu_pkg::data_width]
				| shl[alu_pkg::data_width-1:0];
		3'd4:                                                                  // ror
			shift_res = shr[2*alu_pkg::data_width-1:alu_pkg::data_width]
				| shr[alu_pkg::data_width-1:0];
		default: shift_res = '0;    // unused shift codes
		endcase
	end

endmodule

// File: verilog/alu_top.sv
/* 64-bit integer ALU */

`timescale 1ns/1ps

module alu_top (
	input logic clk,
	input logic rst,
	input logic ld,                          // start strobe for a multiply
	input alu_pkg::alu_opcode_t op,
	input logic [alu_pkg::fn_width-1:0] fn,
	input logic use_imm,
	input alu_pkg::alu_word_t a,
	input alu_pkg::alu_word_t b,
	input alu_pkg::alu_word_t c,
	input alu_pkg::alu_word_t imm,
	output alu_pkg::alu_word_t o,
	output alu_pkg::cause_t exc,
	output logic mul_done
);

	alu_pkg::alu_word_t shift_res;
	alu_pkg::alu_word_t lead_ones;
	alu_pkg::alu_word_t lead_zeros;
	alu_pkg::alu_word_t pop_count;
	alu_pkg::alu_word_t trail_zeros;
	alu_pkg::alu_word_t mul_lo_u;
	alu_pkg::alu_word_t mul_lo_s;
	alu_pkg::alu_word_t mul_hi_s;

	// operation bundle shared by every unit
	alu_op_if opi ();

	assign opi.op = op;
	assign opi.fn = fn;
	assign opi.use_imm = use_imm;
	assign opi.a = a;
	assign opi.b = b;
	assign opi.c = c;
	assign opi.imm = imm;

	// ========================================
	// functional units
	// ========================================
	alu_shifter u_shifter (
		.opi(opi),
		.shift_res(shift_res)
	);

	alu_bitcount u_bitcount (
		.opi(opi),
		.lead_ones(lead_ones),
		.lead_zeros(lead_zeros),
		.pop_count(pop_count),
		.trail_zeros(trail_zeros)
	);

	alu_multiplier u_multiplier (
		.clk(clk),
		.rst(rst),
		.opi(opi),
		.ld(ld),
		.mul_lo_u(mul_lo_u),
		.mul_lo_s(mul_lo_s),
		.mul_hi_s(mul_hi_s),
		.mul_done(mul_done)
	);

	alu_exec u_exec (
		.clk(clk),
		.rst(rst),
		.opi(opi),
		.shift_res(shift_res),
		.lead_ones(lead_ones),
		.lead_zeros(lead_zeros),
		.pop_count(pop_count),
		.trail_zeros(trail_zeros),
		.mul_lo_u(mul_lo_u),
		.mul_lo_s(mul_lo_s),
		.mul_hi_s(mul_hi_s),
		.o(o),
		.exc(exc)
	);

endmodule
